// ==== rtl/arcade_defs.svh ====
// Widths and APB offsets shared by RTL and testbench; ROM_AW also sets the store depth
`ifndef ARCADE_DEFS_SVH
`define ARCADE_DEFS_SVH

// ==============================
// ROM store geometry
// ==============================
`define ROM_AW 15                   // Byte address width
`define ROM_DEPTH (1 << `ROM_AW)    // 32 KiB image

// ==============================
// APB option register block
// ==============================
`define APB_AW 12                   // Decoded address bits
`define APB_DW 32                   // Data bus width

`define CFG_OPT_ADDR  12'h000       // Option register, read/write
`define CFG_CMD_ADDR  12'h004       // Command, bit 0 requests a core reset
`define CFG_STAT_ADDR 12'h008       // Status, read only

`endif

// ==== rtl/arcade_pkg.sv ====
// Shared types for the host shell; struct fields are listed MSB first
`include "arcade_defs.svh"

package arcade_pkg;

	// Download beat from the platform loader
	typedef struct packed {
		logic               wr;     // Byte strobe
		logic [`ROM_AW-1:0] addr;
		logic [7:0]         data;
	} dl_beat_t;

	// One access to the ROM store
	typedef struct packed {
		logic               valid;
		logic               write;
		logic [`ROM_AW-1:0] addr;
		logic [7:0]         wdata;
	} mem_req_t;

	typedef enum logic [1:0] {
		ARB_IDLE  = 2'd0,
		ARB_WRITE = 2'd1,   // Fetch held behind the download
		ARB_READ  = 2'd2
	} arb_state_e;

	// PS/2 set 2 make codes of the game keys
	typedef enum logic [7:0] {
		KEY_F1    = 8'h05,
		KEY_F2    = 8'h06,
		KEY_ALT   = 8'h11,
		KEY_CTRL  = 8'h14,
		KEY_SPACE = 8'h29,
		KEY_LEFT  = 8'h6B,
		KEY_DOWN  = 8'h72,
		KEY_RIGHT = 8'h74,
		KEY_UP    = 8'h75,
		KEY_ESC   = 8'h76
	} key_code_e;

	typedef struct packed {
		logic up, down, left, right;
		logic coin, start1, start2;
		logic ctrl, alt, space;
	} key_state_t;

	// Bit 0 is right, as on the platform joystick word
	typedef struct packed {
		logic bomb, fire, up, down, left, right;
	} joy_t;

	typedef struct packed {
		logic       spare;
		logic       test;
		logic       demo;
		logic       alt_game;
		logic       freeze;
		logic       units;
		logic [1:0] scanlines;
		logic       rotate;     // Bit 0
	} core_opt_t;

	typedef struct packed {
		logic up, down, left, right;
		logic fire, bomb;
		logic start1, start2, coin;
	} player_ctrl_t;

endpackage

// ==== rtl/rom_loader.sv ====
// Download beats must not arrive faster than one per cycle; there is no back-pressure
`timescale 1ns/1ps
`include "arcade_defs.svh"

module rom_loader (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 dl_active,
	input  arcade_pkg::dl_beat_t dl_beat,
	output arcade_pkg::mem_req_t wr_req,
	output logic                 rom_loaded
);

	logic               wr_valid;
	logic [`ROM_AW-1:0] wr_addr;
	logic [7:0]         wr_data;
	logic               dl_active_d;    // For falling edge detect

	// ==============================
	// Control
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_valid    <= 1'b0;
			dl_active_d <= 1'b0;
			rom_loaded  <= 1'b0;
		end else begin
			wr_valid    <= dl_active & dl_beat.wr;
			dl_active_d <= dl_active;
			if (dl_active_d && !dl_active) begin
				rom_loaded <= 1'b1;     // Sticky until reset
			end
		end
	end

	// Beat payload
	always_ff @(posedge clk_sys) begin
		wr_addr <= dl_beat.addr;
		wr_data <= dl_beat.data;
	end

	assign wr_req.valid = wr_valid;
	assign wr_req.write = 1'b1;         // Loader only ever writes
	assign wr_req.addr  = wr_addr;
	assign wr_req.wdata = wr_data;

endmodule

// ==== rtl/rom_arbiter.sv ====
// One fetch outstanding at a time; rom_rd must be held until rom_valid, downloads always win
`timescale 1ns/1ps
`include "arcade_defs.svh"

module rom_arbiter (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 dl_active,
	input  arcade_pkg::mem_req_t wr_req,
	input  logic                 rom_rd,
	input  logic [`ROM_AW-1:0]   rom_addr,
	output arcade_pkg::mem_req_t mem_req,
	input  logic [7:0]           mem_rdata,
	output logic [7:0]           rom_data,
	output logic                 rom_valid
);

	import arcade_pkg::*;

	arb_state_e         state;
	logic [`ROM_AW-1:0] fetch_addr;
	logic               rd_pend;    // Read sent, data due from the store
	logic               store_busy;
	logic               rd_issue;

	assign store_busy = dl_active | wr_req.valid;
	assign rd_issue   = (state == ARB_READ) && !rd_pend && !store_busy;

	// ==============================
	// Store request mux
	// ==============================
	always_comb begin
		if (wr_req.valid) begin
			mem_req = wr_req;
		end else begin
			mem_req.valid = rd_issue;
			mem_req.write = 1'b0;
			mem_req.addr  = fetch_addr;
			mem_req.wdata = '0;
		end
	end

	// ==============================
	// Fetch FSM
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state     <= ARB_IDLE;
			rd_pend   <= 1'b0;
			rom_valid <= 1'b0;
		end else begin
			rom_valid <= 1'b0;
			case (state)
				ARB_IDLE: begin
					// Skip the cycle where the last fetch is still being answered
					if (rom_rd && !rom_valid) begin
						state <= store_busy ? ARB_WRITE : ARB_READ;
					end
				end
				ARB_WRITE: begin
					if (!store_busy) begin
						state <= ARB_READ;
					end
				end
				ARB_READ: begin
					if (rd_pend) begin
						rd_pend   <= 1'b0;
						rom_valid <= 1'b1;
						state     <= ARB_IDLE;
					end else if (rd_issue) begin
						rd_pend <= 1'b1;
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// Fetch address and returned byte
	always_ff @(posedge clk_sys) begin
		if (state == ARB_IDLE && rom_rd) begin
			fetch_addr <= rom_addr;
		end
		if (state == ARB_READ && rd_pend) begin
			rom_data <= mem_rdata;
		end
	end

endmodule

// ==== rtl/rom_store.sv ====
// Contents are undefined until a download has written them; rdata holds the last read
`timescale 1ns/1ps
`include "arcade_defs.svh"

module rom_store (
	input  logic                 clk_sys,
	input  arcade_pkg::mem_req_t mem_req,
	output logic [7:0]           rdata
);

	logic [7:0] mem [`ROM_DEPTH];

	always_ff @(posedge clk_sys) begin
		if (mem_req.valid) begin
			if (mem_req.write) begin
				mem[mem_req.addr] <= mem_req.wdata;
			end else begin
				rdata <= mem[mem_req.addr];     // One cycle latency
			end
		end
	end

endmodule

// ==== rtl/key_decoder.sv ====
// Expects PS/2 set 2 make codes; extended prefixes must already be stripped upstream
`timescale 1ns/1ps

module key_decoder (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   key_strobe,
	input  logic                   key_pressed,
	input  arcade_pkg::key_code_e  key_code,
	output arcade_pkg::key_state_t keys
);

	import arcade_pkg::*;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			keys <= '0;
		end else if (key_strobe) begin
			case (key_code)
				KEY_UP:    keys.up     <= key_pressed;
				KEY_DOWN:  keys.down   <= key_pressed;
				KEY_LEFT:  keys.left   <= key_pressed;
				KEY_RIGHT: keys.right  <= key_pressed;
				KEY_ESC:   keys.coin   <= key_pressed;     // Coin slot
				KEY_F1:    keys.start1 <= key_pressed;
				KEY_F2:    keys.start2 <= key_pressed;
				KEY_CTRL:  keys.ctrl   <= key_pressed;
				KEY_ALT:   keys.alt    <= key_pressed;
				KEY_SPACE: keys.space  <= key_pressed;
				default: ;      // Not a game key
			endcase
		end
	end

endmodule

// ==== rtl/core_config.sv ====
// APB slave with no wait states; only the low 12 address bits are decoded
`timescale 1ns/1ps
`include "arcade_defs.svh"

module core_config (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [`APB_AW-1:0]    paddr,
	input  logic [`APB_DW-1:0]    pwdata,
	output logic [`APB_DW-1:0]    prdata,
	output logic                  pready,
	output logic                  pslverr,
	input  logic                  rom_loaded,
	input  logic                  reset_button,
	output arcade_pkg::core_opt_t opts,
	output logic [7:0]            dip_switch_2,
	output logic                  core_reset
);

	logic access;
	logic addr_hit;
	logic cmd_reset;    // Reset request, lives for the access cycle only

	assign access   = psel & penable;
	assign addr_hit = (paddr == `CFG_OPT_ADDR) || (paddr == `CFG_CMD_ADDR) ||
	                  (paddr == `CFG_STAT_ADDR);
	assign cmd_reset = access & pwrite & (paddr == `CFG_CMD_ADDR) & pwdata[0];

	assign pready  = 1'b1;
	assign pslverr = access & ~addr_hit;

	// ==============================
	// Register file
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			opts       <= '0;
			core_reset <= 1'b1;     // No ROM yet
		end else begin
			if (access && pwrite && paddr == `CFG_OPT_ADDR) begin
				opts <= pwdata[$bits(opts)-1:0];
			end
			core_reset <= cmd_reset | reset_button | ~rom_loaded;
		end
	end

	// Read data
	always_comb begin
		prdata = '0;
		case (paddr)
			`CFG_OPT_ADDR:  prdata[$bits(opts)-1:0] = opts;
			`CFG_STAT_ADDR: prdata[1:0] = {core_reset, rom_loaded};
			default: ;      // Command reads back as zero
		endcase
	end

	// DIP bank 2 is active low, low three bits fixed
	assign dip_switch_2 = {~opts.test, ~opts.demo, ~opts.alt_game, ~opts.freeze,
	                       ~opts.units, 3'b110};

endmodule

// ==== rtl/control_mapper.sv ====
// Both joysticks drive player one; rotate=0 turns the directions for a vertical screen
`timescale 1ns/1ps

module control_mapper (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  arcade_pkg::key_state_t   keys,
	input  arcade_pkg::core_opt_t    opts,
	input  arcade_pkg::joy_t         joy0,
	input  arcade_pkg::joy_t         joy1,
	output arcade_pkg::player_ctrl_t ctrl
);

	import arcade_pkg::*;

	joy_t         joy;
	player_ctrl_t ctrl_next;
	logic         up, down, left, right;

	assign joy = joy0 | joy1;

	// Straight directions before rotation
	assign up    = keys.up    | joy.up;
	assign down  = keys.down  | joy.down;
	assign left  = keys.left  | joy.left;
	assign right = keys.right | joy.right;

	always_comb begin
		if (opts.rotate) begin
			ctrl_next.up    = up;
			ctrl_next.down  = down;
			ctrl_next.left  = left;
			ctrl_next.right = right;
		end else begin
			ctrl_next.up    = left;     // Quarter turn
			ctrl_next.down  = right;
			ctrl_next.left  = down;
			ctrl_next.right = up;
		end
		ctrl_next.fire   = keys.space | joy.fire;
		ctrl_next.bomb   = keys.alt | joy.bomb;
		ctrl_next.start1 = keys.start1;
		ctrl_next.start2 = keys.start2;
		ctrl_next.coin   = keys.coin;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ctrl <= '0;
		end else begin
			ctrl <= ctrl_next;
		end
	end

endmodule

// ==== rtl/arcade_host.sv ====
// Single clock domain; all platform inputs are assumed synchronous to clk_sys
`timescale 1ns/1ps
`include "arcade_defs.svh"

module arcade_host (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	// Download channel
	input  logic                     dl_active,
	input  arcade_pkg::dl_beat_t     dl_beat,
	// CPU program fetch
	input  logic                     rom_rd,
	input  logic [`ROM_AW-1:0]       rom_addr,
	output logic [7:0]               rom_data,
	output logic                     rom_valid,
	// APB option registers
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  logic [`APB_AW-1:0]       paddr,
	input  logic [`APB_DW-1:0]       pwdata,
	output logic [`APB_DW-1:0]       prdata,
	output logic                     pready,
	output logic                     pslverr,
	// Controls
	input  logic                     key_strobe,
	input  logic                     key_pressed,
	input  arcade_pkg::key_code_e    key_code,
	input  arcade_pkg::joy_t         joy0,
	input  arcade_pkg::joy_t         joy1,
	input  logic                     reset_button,
	// To the game core
	output arcade_pkg::core_opt_t    opts,
	output logic [7:0]               dip_switch_2,
	output logic                     core_reset,
	output arcade_pkg::player_ctrl_t ctrl
);

	import arcade_pkg::*;

	mem_req_t   wr_req;
	mem_req_t   mem_req;
	logic [7:0] mem_rdata;
	logic       rom_loaded;
	key_state_t keys;

	// ==============================
	// ROM path
	// ==============================
	rom_loader loader_i (
		.clk_sys, .rst_n, .dl_active, .dl_beat, .wr_req, .rom_loaded
	);

	rom_arbiter arbiter_i (
		.clk_sys, .rst_n, .dl_active, .wr_req, .rom_rd, .rom_addr,
		.mem_req, .mem_rdata, .rom_data, .rom_valid
	);

	rom_store store_i (
		.clk_sys, .mem_req, .rdata(mem_rdata)
	);

	// ==============================
	// Options and controls
	// ==============================
	core_config config_i (
		.clk_sys, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .rom_loaded, .reset_button,
		.opts, .dip_switch_2, .core_reset
	);

	key_decoder keys_i (
		.clk_sys, .rst_n, .key_strobe, .key_pressed, .key_code, .keys
	);

	control_mapper mapper_i (
		.clk_sys, .rst_n, .keys, .opts, .joy0, .joy1, .ctrl
	);

endmodule

// ==== verif/arcade_host_properties.sv ====
// Bound into arcade_host; watches the internal store request and rom_loaded
`timescale 1ns/1ps

module arcade_host_properties (
	input logic                 clk_sys,
	input logic                 rst_n,
	input logic                 dl_active,
	input logic                 rom_rd,
	input logic                 rom_valid,
	input arcade_pkg::mem_req_t mem_req,
	input logic                 rom_loaded,
	input logic                 core_reset,
	input logic                 pready
);

	// ==============================
	// ROM path
	// ==============================
	valid_after_rd: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rom_valid |-> $past(rom_rd))
		else $error("rom_valid without a held rom_rd");

	no_read_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(mem_req.valid && !mem_req.write) |-> !dl_active)
		else $error("Store read issued during a download");

	// Core held in reset until a ROM is in
	reset_until_loaded: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!rom_loaded |-> core_reset)
		else $error("core_reset low with no ROM loaded");

	pready_high: assert property (@(posedge clk_sys) pready)
		else $error("pready dropped");

endmodule

bind arcade_host arcade_host_properties props_i (
	.clk_sys(clk_sys), .rst_n(rst_n), .dl_active(dl_active), .rom_rd(rom_rd),
	.rom_valid(rom_valid), .mem_req(mem_req), .rom_loaded(rom_loaded),
	.core_reset(core_reset), .pready(pready)
);

// ==== verif/arcade_host_tb.sv ====
// Run from the project root so the stimulus path resolves; RD only fetches from the last download
`timescale 1ns/1ps
`include "arcade_defs.svh"

module arcade_host_tb;

	import arcade_pkg::*;

	logic               clk_sys, rst_n;
	logic               dl_active, rom_rd, rom_valid;
	dl_beat_t           dl_beat;
	logic [`ROM_AW-1:0] rom_addr;
	logic [7:0]         rom_data, dip_switch_2;
	logic               psel, penable, pwrite, pready, pslverr;
	logic [`APB_AW-1:0] paddr;
	logic [`APB_DW-1:0] pwdata, prdata;
	logic               key_strobe, key_pressed, reset_button, core_reset;
	key_code_e          key_code;
	joy_t               joy0, joy1;
	core_opt_t          opts;
	player_ctrl_t       ctrl;

	logic [7:0]         model [`ROM_DEPTH];     // Bytes written by downloads
	logic [31:0]        rng = 32'h33d412c8;
	logic [`ROM_AW-1:0] last_base;
	int                 last_len;
	int                 nlines = 0;
	int                 errors = 0;
	int                 test_errs;
	string              tname;

	arcade_host dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// DIP bank 2: option bits 3 to 7 (units up to test) inverted, over a fixed 110
	function automatic logic [7:0] dip_rule(input logic [8:0] opt_word);
		return {~opt_word[7:3], 3'b110};
	endfunction

	// ==============================
	// Compare tasks
	// ==============================
	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("Error %s: expected %02h actual %02h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_ctrl(input string name, input player_ctrl_t exp, input player_ctrl_t act);
		if (act !== exp) begin
			$display("Error %s: expected ctrl %03h actual %03h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_opt(input string name, input core_opt_t exp, input core_opt_t act);
		if (act !== exp) begin
			$display("Error %s: expected opts %03h actual %03h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_word(input string name, input logic [`APB_DW-1:0] exp,
	                          input logic [`APB_DW-1:0] act);
		if (act !== exp) begin
			$display("Error %s: expected %08h actual %08h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error %s: expected %b actual %b", name, exp, act);
			test_errs++;
		end
	endtask

	// ==============================
	// Bus drivers
	// ==============================
	task automatic fetch(input logic [`ROM_AW-1:0] addr, output logic [7:0] data);
		int waited;
		waited = 0;
		@(negedge clk_sys);
		rom_rd   <= 1'b1;       // Held until rom_valid
		rom_addr <= addr;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (!rom_valid && waited < 500);
		if (!rom_valid) begin
			$display("%s: fetch at %04h got no rom_valid", tname, addr);
			test_errs++;
		end else if (dl_active) begin
			$display("%s: rom_valid came while the download was still active", tname);
			test_errs++;
		end
		data = rom_data;
		rom_rd <= 1'b0;
		@(negedge clk_sys);
		if (rom_valid) begin
			$display("%s: rom_valid lasted more than one cycle", tname);
			test_errs++;
		end
	endtask

	task automatic apb_xfer(input logic wr, input logic [`APB_AW-1:0] addr,
	                        input logic [`APB_DW-1:0] wdata,
	                        output logic [`APB_DW-1:0] rdata, output logic err);
		@(negedge clk_sys);
		psel    <= 1'b1;        // Setup
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(negedge clk_sys);
		penable <= 1'b1;        // Access
		@(negedge clk_sys);
		rdata = prdata;
		err   = pslverr;
		check_bit(tname, 1'b1, pready);     // No wait states
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	// ==============================
	// Tests
	// ==============================
	task automatic download(input logic [`ROM_AW-1:0] base, input int len, input int off);
		logic [7:0] got;
		last_base = base;
		last_len  = len;
		fork
			begin
				for (int i = 0; i < len; i++) begin
					@(negedge clk_sys);
					rng = xorshift(rng);
					model[base + `ROM_AW'(i)] = rng[7:0];
					dl_active    <= 1'b1;
					dl_beat.wr   <= 1'b1;
					dl_beat.addr <= base + `ROM_AW'(i);
					dl_beat.data <= rng[7:0];
				end
				@(negedge clk_sys);
				dl_active  <= 1'b0;
				dl_beat.wr <= 1'b0;
			end
			begin
				if (off < len) begin    // Fetch raised in the middle of the download
					repeat (3) @(negedge clk_sys);
					fetch(base + `ROM_AW'(off), got);
					check_byte(tname, model[base + `ROM_AW'(off)], got);
				end
			end
		join
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic random_reads(input int count);
		logic [`ROM_AW-1:0] addr;
		logic [7:0]         got;
		repeat (count) begin
			rng  = xorshift(rng);
			addr = last_base + `ROM_AW'(rng % last_len);
			fetch(addr, got);
			check_byte(tname, model[addr], got);
		end
	endtask

	task automatic reset_cause(input int kind, input int cycles, input logic exp);
		logic [`APB_DW-1:0] rd;
		logic               err;
		if (kind == 1) begin
			apb_xfer(1'b1, `CFG_CMD_ADDR, 32'd1, rd, err);     // Command reset
		end else begin
			@(negedge clk_sys);
			reset_button <= 1'b1;
			repeat (cycles) @(negedge clk_sys);
		end
		check_bit(tname, exp, core_reset);
		reset_button <= 1'b0;
		repeat (2) @(negedge clk_sys);
		check_bit(tname, 1'b0, core_reset);     // ROM is loaded by now
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		string              line;
		logic [31:0]        op, a, b, c;
		logic [`APB_DW-1:0] rd;
		logic               err;
		int                 fd, n, test_no;
		dl_active = 1'b0;
		dl_beat = '0;
		rom_rd = 1'b0;
		rom_addr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = KEY_F1;
		joy0 = '0;
		joy1 = '0;
		reset_button = 1'b0;
		rst_n = 1'b0;
		test_no = 0;
		fd = $fopen("verif/arcade_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open verif/arcade_stimulus.txt");
			errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				nlines++;     // Sizes the watchdog
			end
			$fclose(fd);
			fd = $fopen("verif/arcade_stimulus.txt", "r");
		end
		repeat (5) @(negedge clk_sys);
		rst_n <= 1'b1;
		while (fd != 0 && $fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") continue;
			op = '0;
			n = $sscanf(line, "%s %h %h %h", op, a, b, c);
			test_no++;
			test_errs = 0;
			tname = $sformatf("test %0d (line op %0d)", test_no, n);
			case (op)
				32'("DL"): download(a[`ROM_AW-1:0], int'(b), int'(c));
				32'("RD"): random_reads(int'(a));
				32'("RST"): reset_cause(int'(a), int'(b), c[0]);
				32'("KEY"): begin
					@(negedge clk_sys);
					key_strobe  <= 1'b1;
					key_pressed <= b[0];
					key_code    <= key_code_e'(a[7:0]);
					@(negedge clk_sys);
					key_strobe <= 1'b0;
					@(negedge clk_sys);     // Decoder then mapper register
					check_ctrl(tname, player_ctrl_t'(c[8:0]), ctrl);
				end
				32'("JOY"): begin
					@(negedge clk_sys);
					joy0 <= joy_t'(a[5:0]);
					joy1 <= joy_t'(b[5:0]);
					repeat (2) @(negedge clk_sys);
					check_ctrl(tname, player_ctrl_t'(c[8:0]), ctrl);
				end
				32'("APBW"): begin
					apb_xfer(1'b1, a[`APB_AW-1:0], b, rd, err);
					check_bit(tname, c[0], err);
					if (a[`APB_AW-1:0] == `CFG_OPT_ADDR) begin
						check_opt(tname, core_opt_t'(b[8:0]), opts);
						check_byte(tname, dip_rule(b[8:0]), dip_switch_2);
					end
				end
				32'("APBR"): begin
					apb_xfer(1'b0, a[`APB_AW-1:0], '0, rd, err);
					check_word(tname, b, rd);
					check_bit(tname, c[0], err);
				end
				default: begin
					$display("%s: unknown opcode in the stimulus file", tname);
					test_errs++;
				end
			endcase
			if (test_errs == 0) $display("%s: ok", tname);
			else $display("%s: FAILED", tname);
			errors += test_errs;
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		$display("Tests run %0d, errors %0d", test_no, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// Watchdog, 200 cycles per stimulus line
	initial begin
		wait (nlines > 0);
		repeat (nlines * 200) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, a test did not finish", nlines * 200);
		$display("Done: errors found");
		$finish;
	end

endmodule

// ==== verif/arcade_stimulus.txt ====
# op a b c (hex): DL base len fetch_off(FFFF none) | RD fetches 0 0 | RST kind(1 cmd 2 button) cycles core_reset
# KEY code pressed ctrl | JOY joy0 joy1 ctrl | APBW addr data pslverr | APBR addr rdata pslverr
APBR 000 0 0
APBR 008 2 0
DL 0100 40 FFFF
APBR 008 1 0
RD 8 0 0
DL 2000 30 28
RD 6 0 0
RST 1 0 1
RST 2 4 1
APBR 008 1 0
APBW 000 1AA 0
APBR 000 1AA 0
APBW 00C 5 1
APBR 010 0 1
APBR 004 0 0
KEY 75 1 020
KEY 29 1 030
KEY 75 0 010
JOY 01 00 090
APBW 000 001 0
JOY 00 08 110
KEY 05 1 114
KEY 76 1 115
KEY 11 1 11D
JOY 30 00 01D
KEY 14 1 01D
KEY 33 1 01D
KEY 6B 1 05D
APBW 000 000 0
JOY 00 00 11D

// ==== sources.f ====
+incdir+rtl
rtl/arcade_pkg.sv
rtl/rom_loader.sv
rtl/rom_arbiter.sv
rtl/rom_store.sv
rtl/key_decoder.sv
rtl/core_config.sv
rtl/control_mapper.sv
rtl/arcade_host.sv
verif/arcade_host_properties.sv
verif/arcade_host_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module arcade_host_tb -o arcade_sim

out="$(./obj_dir/arcade_sim)"
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
	exit 0
else
	exit 1
fi
